//--- hdl/mrd_config.svh
`ifndef MRD_CONFIG_SVH
`define MRD_CONFIG_SVH

// bits per real or imaginary part of one complex point
`define MRD_DATA_W 16

// group address bits, one address selects a whole group
`define MRD_ADDR_W 4

// groups held by each bank
`define MRD_DEPTH 16

// fraction bits of the Q1.14 unit root coefficients
`define MRD_COEF_FRAC 14

// complex points per group, enough for the largest radix
`define MRD_LANES 5

`endif

//--- hdl/mrd_pkg.sv
`default_nettype none
`include "mrd_config.svh"

package mrd_pkg;

	// one complex point, real part in the upper half of the word
	typedef struct packed {
		logic signed [`MRD_DATA_W-1:0] d_real;
		logic signed [`MRD_DATA_W-1:0] d_imag;
	} cplx_t;

	// one group of points as it moves between banks and butterfly
	// factor is the radix, 2 to 5
	typedef struct packed {
		logic                         valid;
		logic [2:0]                   factor;
		logic [`MRD_ADDR_W-1:0]       bank_addr;
		cplx_t [`MRD_LANES-1:0]       data;
	} group_t;

	// Q1.14 coefficient, 16384 is one
	typedef logic signed [15:0] coef_t;

	// real part of W(r, m) = exp(-j*2*pi*m/r), row r, column m
	localparam coef_t [2:5][0:4] coef_cos = '{
		'{16'sd16384, -16'sd16384, 16'sd0, 16'sd0, 16'sd0},
		'{16'sd16384, -16'sd8192, -16'sd8192, 16'sd0, 16'sd0},
		'{16'sd16384, 16'sd0, -16'sd16384, 16'sd0, 16'sd0},
		'{16'sd16384, 16'sd5063, -16'sd13255, -16'sd13255, 16'sd5063}
	};

	// imaginary part of the same root, already carrying the minus sign
	// so a product is plain (a + jb) * (c + js)
	localparam coef_t [2:5][0:4] coef_sin = '{
		'{16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0},
		'{16'sd0, -16'sd14189, 16'sd14189, 16'sd0, 16'sd0},
		'{16'sd0, -16'sd16384, 16'sd0, 16'sd16384, 16'sd0},
		'{16'sd0, -16'sd15582, -16'sd9630, 16'sd9630, 16'sd15582}
	};

endpackage

`default_nettype wire

//--- hdl/mrd_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_config.svh"

module mrd_bank_mem (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire mrd_pkg::group_t        host_wr,
	input  wire mrd_pkg::group_t        eng_wr,
	input  wire logic                   rd_en,
	input  wire logic [`MRD_ADDR_W-1:0] rd_addr,
	output mrd_pkg::group_t             rd
);

	import mrd_pkg::*;

	// five lanes share one address
	cplx_t [`MRD_LANES-1:0] mem_data [`MRD_DEPTH];
	// radix stored alongside each group
	logic [2:0] mem_factor [`MRD_DEPTH];

	// write port actually used this cycle
	group_t wr;

	// engine results win over host loads
	always_comb begin
		wr = eng_wr.valid ? eng_wr : host_wr;
	end

	always_ff @(posedge clk) begin
		if (wr.valid) begin
			mem_data[wr.bank_addr] <= wr.data;
			mem_factor[wr.bank_addr] <= wr.factor;
		end
	end

	// registered read, returns data from before a same-cycle write
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd.factor <= mem_factor[rd_addr];
			rd.bank_addr <= rd_addr;
			rd.data <= mem_data[rd_addr];
		end
		if (reset) begin
			rd.valid <= 1'b0;
		end else begin
			rd.valid <= rd_en;
		end
	end

	// host loads are only legal while no pass is running
	assert property (@(posedge clk) disable iff (reset)
		!(host_wr.valid && eng_wr.valid))
		else $error("bank write collision between host and engine ports");

endmodule

`default_nettype wire

//--- hdl/mrd_switch_rdx2345.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_switch_rdx2345 (
	input  wire logic            sw,
	input  wire mrd_pkg::group_t from_mem0,
	input  wire mrd_pkg::group_t from_mem1,
	input  wire mrd_pkg::group_t from_rdx2345,
	output mrd_pkg::group_t      to_mem0,
	output mrd_pkg::group_t      to_mem1,
	output mrd_pkg::group_t      to_rdx2345
);

	// sw low makes bank 0 the source and bank 1 the result bank
	// sw high swaps the roles for the next pass
	always_comb begin
		// source bank into the butterfly
		to_rdx2345 = (sw) ? from_mem1 : from_mem0;

		// results to the bank that is not the source
		// the idle write link is held at zero including valid
		to_mem0 = (sw) ? from_rdx2345 : '0;
		to_mem1 = (sw) ? '0 : from_rdx2345;

		// engine reads only ever come back from the source bank
		assert ((sw ? from_mem0.valid : from_mem1.valid) !== 1'b1)
			else $error("switch sees an engine read from the result bank");
	end

endmodule

`default_nettype wire

//--- hdl/mrd_rdx2345.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_config.svh"

module mrd_rdx2345 (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire mrd_pkg::group_t in_grp,
	output mrd_pkg::group_t      out_grp
);

	import mrd_pkg::*;

	localparam int LANES = `MRD_LANES;
	localparam int DW = `MRD_DATA_W;

	// exponent of the unit root for a fixed k*n and a given radix
	function automatic logic [2:0] root_exp(input int unsigned p, input logic [2:0] r);
		case (r)
			3'd3: root_exp = 3'(p % 3);
			3'd4: root_exp = 3'(p % 4);
			3'd5: root_exp = 3'(p % 5);
			default: root_exp = 3'(p % 2);
		endcase
	endfunction

	// complex product with Q1.14 coefficient, rounded by shift
	function automatic cplx_t cmul(input cplx_t x, input coef_t c, input coef_t s);
		logic signed [2*DW:0] pr;
		logic signed [2*DW:0] pi;
		pr = x.d_real * c - x.d_imag * s;
		pi = x.d_real * s + x.d_imag * c;
		cmul.d_real = DW'(pr >>> `MRD_COEF_FRAC);
		cmul.d_imag = DW'(pi >>> `MRD_COEF_FRAC);
	endfunction

	// factor kept inside the table range even for idle cycles
	logic [2:0] fct;

	// stage one, indexed [output lane][input lane]
	cplx_t prod [LANES][LANES];
	logic s1_valid;
	logic [2:0] s1_factor;
	logic [`MRD_ADDR_W-1:0] s1_addr;

	// stage two sums before the output register
	cplx_t [LANES-1:0] sum_data;

	assign fct = (in_grp.factor >= 3'd2 && in_grp.factor <= 3'd5) ? in_grp.factor : 3'd2;

	for (genvar k = 0; k < LANES; k++) begin : g_out
		for (genvar n = 0; n < LANES; n++) begin : g_in
			logic [2:0] e;

			assign e = root_exp(k * n, fct);

			// inputs at or above the radix do not take part
			always_ff @(posedge clk) begin
				if (n >= fct) begin
					prod[k][n] <= '0;
				end else begin
					prod[k][n] <= cmul(in_grp.data[n], coef_cos[fct][e], coef_sin[fct][e]);
				end
			end
		end
	end

	// sideband follows the products
	always_ff @(posedge clk) begin
		s1_factor <= in_grp.factor;
		s1_addr <= in_grp.bank_addr;
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_grp.valid;
		end
	end

	// sum wraps at DW bits, lanes at or above the radix read zero
	always_comb begin
		logic signed [DW-1:0] acc_r;
		logic signed [DW-1:0] acc_i;
		for (int k = 0; k < LANES; k++) begin
			acc_r = '0;
			acc_i = '0;
			for (int n = 0; n < LANES; n++) begin
				acc_r = acc_r + prod[k][n].d_real;
				acc_i = acc_i + prod[k][n].d_imag;
			end
			if (k >= int'(s1_factor)) begin
				sum_data[k] = '0;
			end else begin
				sum_data[k].d_real = acc_r;
				sum_data[k].d_imag = acc_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		out_grp.factor <= s1_factor;
		out_grp.bank_addr <= s1_addr;
		out_grp.data <= sum_data;
		if (reset) begin
			out_grp.valid <= 1'b0;
		end else begin
			out_grp.valid <= s1_valid;
		end
	end

	// the controller only ever passes a radix of 2 to 5
	assert property (@(posedge clk) disable iff (reset)
		in_grp.valid |-> (in_grp.factor inside {[3'd2:3'd5]}))
		else $error("butterfly got radix %0d", in_grp.factor);

endmodule

`default_nettype wire

//--- hdl/mrd_pass_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_config.svh"

module mrd_pass_ctrl (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   start,
	input  wire logic [2:0]             pass_factor,
	input  wire logic [`MRD_ADDR_W:0]   pass_groups,
	input  wire logic                   host_rd_en,
	input  wire logic                   host_rd_bank,
	input  wire logic [`MRD_ADDR_W-1:0] host_rd_addr,
	input  wire logic                   write_seen,
	output logic                        rd_en0,
	output logic                        rd_en1,
	output logic [`MRD_ADDR_W-1:0]      rd_addr,
	output logic [2:0]                  cur_factor,
	output logic                        sw,
	output logic                        busy,
	output logic                        done
);

	typedef enum logic [1:0] {s_idle, s_run, s_done} state_t;

	state_t state;
	// reads issued and results written back in this pass
	logic [`MRD_ADDR_W:0] iss_cnt;
	logic [`MRD_ADDR_W:0] ret_cnt;
	logic [`MRD_ADDR_W:0] groups_q;
	logic issue;
	logic host_rd;

	// one read per cycle until every group is issued
	assign issue = (state == s_run) && (iss_cnt < groups_q);
	// host reads are served only between passes
	assign host_rd = (state == s_idle) && host_rd_en;

	// engine reads always come from the source bank
	assign rd_en0 = (issue && !sw) || (host_rd && !host_rd_bank);
	assign rd_en1 = (issue && sw) || (host_rd && host_rd_bank);
	assign rd_addr = issue ? iss_cnt[`MRD_ADDR_W-1:0] : host_rd_addr;

	assign busy = (state != s_idle);
	assign done = (state == s_done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			iss_cnt <= '0;
			ret_cnt <= '0;
			groups_q <= '0;
			cur_factor <= 3'd2;
			sw <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					// an empty pass would never finish
					if (start && pass_groups != '0) begin
						state <= s_run;
						iss_cnt <= '0;
						ret_cnt <= '0;
						groups_q <= pass_groups;
						cur_factor <= pass_factor;
					end
				end
				s_run: begin
					if (issue) begin
						iss_cnt <= iss_cnt + 1'b1;
					end
					if (write_seen) begin
						ret_cnt <= ret_cnt + 1'b1;
						// last write, destination becomes next source
						if (ret_cnt + 1'b1 == groups_q) begin
							state <= s_done;
							sw <= ~sw;
						end
					end
				end
				s_done: state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	// butterfly results only arrive for reads of a running pass
	assert property (@(posedge clk) disable iff (reset)
		write_seen |-> (state == s_run))
		else $error("bank write returned outside a pass");

endmodule

`default_nettype wire

//--- hdl/mrd_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_config.svh"

module mrd_top (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire mrd_pkg::group_t        load,
	input  wire logic                   start,
	input  wire logic [2:0]             pass_factor,
	input  wire logic [`MRD_ADDR_W:0]   pass_groups,
	input  wire logic                   host_rd_en,
	input  wire logic                   host_rd_bank,
	input  wire logic [`MRD_ADDR_W-1:0] host_rd_addr,
	output logic                        busy,
	output logic                        done,
	output logic                        sw,
	output mrd_pkg::group_t             rd_data
);

	import mrd_pkg::*;

	group_t bank0_rd;
	group_t bank1_rd;
	// bank outputs as seen by the switch
	group_t eng0_rd;
	group_t eng1_rd;
	group_t to_rdx2345;
	group_t from_rdx2345;
	group_t to_mem0;
	group_t to_mem1;

	logic rd_en0;
	logic rd_en1;
	logic [`MRD_ADDR_W-1:0] rd_addr;
	logic [2:0] cur_factor;
	logic write_seen;
	// a read issued while busy is an engine read
	logic busy_q;
	logic rd_bank_q;

	always_ff @(posedge clk) begin
		rd_bank_q <= host_rd_bank;
		if (reset) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= busy;
		end
	end

	// host reads must not reach the butterfly
	// pass radix replaces the stored one
	always_comb begin
		eng0_rd = bank0_rd;
		eng0_rd.valid = bank0_rd.valid && busy_q;
		eng0_rd.factor = cur_factor;
		eng1_rd = bank1_rd;
		eng1_rd.valid = bank1_rd.valid && busy_q;
		eng1_rd.factor = cur_factor;
	end

	// host sees only its own reads
	always_comb begin
		rd_data = rd_bank_q ? bank1_rd : bank0_rd;
		rd_data.valid = (rd_bank_q ? bank1_rd.valid : bank0_rd.valid) && !busy_q;
	end

	assign write_seen = to_mem0.valid || to_mem1.valid;

	mrd_pass_ctrl ctrl_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.pass_factor(pass_factor),
		.pass_groups(pass_groups),
		.host_rd_en(host_rd_en),
		.host_rd_bank(host_rd_bank),
		.host_rd_addr(host_rd_addr),
		.write_seen(write_seen),
		.rd_en0(rd_en0),
		.rd_en1(rd_en1),
		.rd_addr(rd_addr),
		.cur_factor(cur_factor),
		.sw(sw),
		.busy(busy),
		.done(done)
	);

	// only bank 0 takes host loads
	mrd_bank_mem bank0_inst (
		.clk(clk),
		.reset(reset),
		.host_wr(load),
		.eng_wr(to_mem0),
		.rd_en(rd_en0),
		.rd_addr(rd_addr),
		.rd(bank0_rd)
	);

	mrd_bank_mem bank1_inst (
		.clk(clk),
		.reset(reset),
		.host_wr('0),
		.eng_wr(to_mem1),
		.rd_en(rd_en1),
		.rd_addr(rd_addr),
		.rd(bank1_rd)
	);

	mrd_switch_rdx2345 switch_inst (
		.sw(sw),
		.from_mem0(eng0_rd),
		.from_mem1(eng1_rd),
		.from_rdx2345(from_rdx2345),
		.to_mem0(to_mem0),
		.to_mem1(to_mem1),
		.to_rdx2345(to_rdx2345)
	);

	mrd_rdx2345 rdx_inst (
		.clk(clk),
		.reset(reset),
		.in_grp(to_rdx2345),
		.out_grp(from_rdx2345)
	);

endmodule

`default_nettype wire

//--- verif/mrd_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mrd_config.svh"

module mrd_tb;

	import mrd_pkg::*;

	// five passes of at most 16 groups, two loads of 16 and seven readbacks stay well below this
	localparam int TIMEOUT_CYCLES = 2000;

	logic clk;
	logic reset;
	group_t load;
	logic start;
	logic [2:0] pass_factor;
	logic [`MRD_ADDR_W:0] pass_groups;
	logic host_rd_en;
	logic host_rd_bank;
	logic [`MRD_ADDR_W-1:0] host_rd_addr;
	logic busy;
	logic done;
	logic sw;
	group_t rd_data;

	// model of both banks indexed [bank][group address]
	group_t bank_m [2][`MRD_DEPTH];
	// groups expected on rd_data in read order
	group_t exp_q [$];
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int done_cnt = 0;
	int cycle_cnt = 0;

	mrd_top mrd_top_inst (
		.clk(clk),
		.reset(reset),
		.load(load),
		.start(start),
		.pass_factor(pass_factor),
		.pass_groups(pass_groups),
		.host_rd_en(host_rd_en),
		.host_rd_bank(host_rd_bank),
		.host_rd_addr(host_rd_addr),
		.busy(busy),
		.done(done),
		.sw(sw),
		.rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_group(input string name, input group_t got, input group_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// done pulses and returned groups, seen mid cycle on the falling edge
	always @(negedge clk) begin
		if (done === 1'b1) begin
			done_cnt = done_cnt + 1;
		end
		if (rd_data.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("read data arrived at %0t with no host read pending", $time);
			end else begin
				check_group("rd_data", rd_data, exp_q.pop_front());
			end
		end
	end

	// lane k sums x_n * W(r, k*n mod r) over n < r with each product shifted down by 14
	function automatic group_t ref_dft(input group_t src, input int r);
		group_t res;
		int e;
		int pr;
		int pi;
		logic signed [15:0] acc_r;
		logic signed [15:0] acc_i;
		res = '0;
		res.valid = 1'b1;
		res.factor = 3'(r);
		res.bank_addr = src.bank_addr;
		for (int k = 0; k < r; k++) begin
			acc_r = '0;
			acc_i = '0;
			for (int n = 0; n < r; n++) begin
				e = (k * n) % r;
				pr = int'(src.data[n].d_real) * int'(coef_cos[r][e])
					- int'(src.data[n].d_imag) * int'(coef_sin[r][e]);
				pi = int'(src.data[n].d_real) * int'(coef_sin[r][e])
					+ int'(src.data[n].d_imag) * int'(coef_cos[r][e]);
				// sums wrap at 16 bits
				acc_r = acc_r + 16'(pr >>> `MRD_COEF_FRAC);
				acc_i = acc_i + 16'(pi >>> `MRD_COEF_FRAC);
			end
			res.data[k].d_real = acc_r;
			res.data[k].d_imag = acc_i;
		end
		return res;
	endfunction

	function automatic group_t rand_group(input int addr);
		group_t g;
		g = '0;
		g.valid = 1'b1;
		// stored factor is arbitrary since a pass replaces it
		g.factor = 3'($urandom_range(7));
		g.bank_addr = `MRD_ADDR_W'(addr);
		for (int n = 0; n < `MRD_LANES; n++) begin
			g.data[n].d_real = 16'($urandom_range(8191)) - 16'd4096;
			g.data[n].d_imag = 16'($urandom_range(8191)) - 16'd4096;
		end
		return g;
	endfunction

	// drive point just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_groups(input int n);
		for (int a = 0; a < n; a++) begin
			next_cycle();
			load = rand_group(a);
			bank_m[0][a] = load;
		end
		next_cycle();
		load = '0;
	endtask

	task automatic read_bank(input logic bank, input int n);
		for (int a = 0; a < n; a++) begin
			next_cycle();
			host_rd_en = 1'b1;
			host_rd_bank = bank;
			host_rd_addr = `MRD_ADDR_W'(a);
			exp_q.push_back(bank_m[bank][a]);
		end
		next_cycle();
		host_rd_en = 1'b0;
		// last group is checked one falling edge before this one
		repeat (2) @(negedge clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d host reads from bank %0d never returned data", exp_q.size(), bank);
			exp_q.delete();
		end
	endtask

	// one pass with an optional second start while busy
	task automatic run_pass(input int r, input int g, input bit poke_start);
		int t0;
		int done_mark;
		logic src;
		src = sw;
		done_mark = done_cnt;
		next_cycle();
		start = 1'b1;
		pass_factor = 3'(r);
		pass_groups = 5'(g);
		t0 = cycle_cnt;
		next_cycle();
		start = 1'b0;
		if (poke_start) begin
			// a different radix here would show up in the results if it were taken
			next_cycle();
			start = 1'b1;
			pass_factor = 3'd2;
			next_cycle();
			start = 1'b0;
			pass_factor = 3'(r);
		end
		while (done !== 1'b1) begin
			@(negedge clk);
		end
		check_int("pass latency", cycle_cnt - t0, g + 4);
		check_bit("sw", sw, ~src);
		check_bit("busy", busy, 1'b1);
		for (int a = 0; a < g; a++) begin
			bank_m[~src][a] = ref_dft(bank_m[src][a], r);
		end
		@(negedge clk);
		check_bit("done", done, 1'b0);
		check_bit("busy", busy, 1'b0);
		repeat (4) @(negedge clk);
		check_int("done pulses", done_cnt - done_mark, 1);
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	initial begin
		void'($urandom(78));
		reset = 1'b1;
		load = '0;
		start = 1'b0;
		pass_factor = 3'd2;
		pass_groups = '0;
		host_rd_en = 1'b0;
		host_rd_bank = 1'b0;
		host_rd_addr = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("sw", sw, 1'b0);
		load_groups(16);
		read_bank(1'b0, 16);
		end_test("reset and load");

		// bank 0 to bank 1
		run_pass(4, 8, 1'b0);
		read_bank(1'b1, 8);
		end_test("radix-4 pass");

		// bank 1 back to bank 0 and then bank 0 to bank 1 again
		run_pass(3, 8, 1'b0);
		run_pass(5, 8, 1'b0);
		read_bank(1'b0, 8);
		read_bank(1'b1, 8);
		end_test("radix-3 then radix-5 ping-pong");

		// lanes 2 to 4 of the reference are zero and bank 1 stays untouched
		run_pass(2, 8, 1'b0);
		read_bank(1'b0, 8);
		read_bank(1'b1, 8);
		end_test("radix-2 pass");

		load_groups(16);
		run_pass(5, 16, 1'b1);
		read_bank(1'b1, 16);
		end_test("start while busy");

		$display("all tests finished: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/mrd_pkg.sv
hdl/mrd_bank_mem.sv
hdl/mrd_switch_rdx2345.sv
hdl/mrd_rdx2345.sv
hdl/mrd_pass_ctrl.sv
hdl/mrd_top.sv
verif/mrd_tb.sv

//--- Makefile
# Verilator build and run of the mixed-radix pass engine testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= mrd_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass message
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
